/* common/rom_check_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The digest is a simple mixing function standing in for SHA-3 and gives no security
// DigestW must equal RomTopCount * DataW
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rom_check_pkg;

  localparam int RomDepth       = 32;
  localparam int RomTopCount    = 2;
  localparam int RomNonTopCount = RomDepth - RomTopCount;
  localparam int AddrW          = 5;
  localparam int DataW          = 32;
  localparam int DigestW        = RomTopCount * DataW;
  localparam int DigestRounds   = 2;
  // Wide enough to hold DigestRounds itself as the loaded round count
  localparam int RoundCntW      = $clog2(DigestRounds + 1);

  localparam logic [DigestW-1:0] DigestInit = 64'h6a09_e667_f3bc_c908;
  localparam logic [DigestW-1:0] RoundConst = 64'h9e37_79b9_7f4a_7c15;

  typedef logic [RomDepth-1:0][DataW-1:0] rom_image_t;

  typedef struct packed {
    logic             req;
    logic [AddrW-1:0] addr;
  } rom_req_t;

  typedef struct packed {
    logic             rvalid;
    logic [DataW-1:0] rdata;
  } rom_rsp_t;

  typedef struct packed {
    logic done;
    logic good;
  } check_status_t;

  // One sub-round: rotate left by 13, xor in the word twice, add a constant
  // The round index is folded into the low half so the sub-rounds differ
  function automatic logic [DigestW-1:0] digest_round(input logic [DigestW-1:0] d,
                                                     input logic [DataW-1:0]   w,
                                                     input int unsigned        r);
    logic [DigestW-1:0] rot;
    rot = {d[DigestW-14:0], d[DigestW-1:DigestW-13]};
    return (rot ^ {w, w ^ DataW'(r)}) + RoundConst;
  endfunction

  // Full step for one absorbed word, the digest engine spreads it over DigestRounds cycles
  function automatic logic [DigestW-1:0] digest_step(input logic [DigestW-1:0] d,
                                                    input logic [DataW-1:0]   w);
    logic [DigestW-1:0] acc;
    acc = d;
    for (int unsigned r = 0; r < DigestRounds; r++) begin
      acc = digest_round(acc, w, r);
    end
    return acc;
  endfunction

  // Nontop words follow a fixed formula and the top words hold their digest, low half first
  function automatic rom_image_t build_image();
    rom_image_t         img;
    logic [DigestW-1:0] d;
    img = '0;
    d   = DigestInit;
    for (int a = 0; a < RomNonTopCount; a++) begin
      img[a] = (DataW'(a) * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
      d      = digest_step(d, img[a]);
    end
    for (int i = 0; i < RomTopCount; i++) begin
      img[RomNonTopCount + i] = d[i*DataW +: DataW];
    end
    return img;
  endfunction

endpackage

`default_nettype wire

/* hw/rom_check/rom_check_counter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Starts reading at address 0 after reset and needs at least 2 nontop words
// done_o is sticky and the request stays high after done while the mux ignores it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rom_check_counter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            data_rdy_i,
  output rom_check_pkg::rom_req_t         rom_req_o,
  output logic                            data_vld_o,
  output logic                            data_last_nontop_o,
  output logic                            done_o,
  output logic [rom_check_pkg::AddrW-1:0] data_addr_o
);
  import rom_check_pkg::*;

  logic             go;
  logic             req_q;
  logic             vld_q;
  logic [AddrW-1:0] addr_q;
  logic [AddrW-1:0] addr_d;
  logic             done_q;
  logic             done_d;
  logic             last_nontop_q;
  logic             last_nontop_d;

  // We are at the top word and there is nothing more to fetch
  assign done_d = addr_q == AddrW'(RomDepth - 1);

  // The word after this one is the last one that gets hashed
  assign last_nontop_d = addr_q == AddrW'(RomNonTopCount - 2);

  assign addr_d = addr_q + AddrW'(1);

  // A word moves on a vld and rdy edge but the top word only raises done
  assign go = data_rdy_i & vld_q & ~done_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (done_d) begin
      done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q        <= '0;
      last_nontop_q <= 1'b0;
    end else if (go) begin
      addr_q        <= addr_d;
      last_nontop_q <= last_nontop_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      vld_q <= 1'b0;
    end else begin
      // Request goes out from the first cycle after reset
      req_q <= 1'b1;
      // ROM data lands one cycle behind the request
      vld_q <= req_q;
    end
  end

  // Look ahead on the read address so the ROM streams a word per cycle
  assign rom_req_o          = '{req: req_q, addr: go ? addr_d : addr_q};
  assign data_vld_o         = vld_q & ~done_q;
  assign data_last_nontop_o = last_nontop_q;
  assign data_addr_o        = addr_q;
  assign done_o             = done_q;

  // Done freezes the address on the top word for good
  DoneAtTop_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> data_addr_o == AddrW'(RomDepth - 1));

  // The last-nontop flag travels with the address of the last hashed word
  LastNontopAddr_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_last_nontop_o |-> data_addr_o == AddrW'(RomNonTopCount - 1));

endmodule

`default_nettype wire

/* hw/rom_check/rom_check_rom.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Contents are fixed by the Image parameter at elaboration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rom_check_rom #(
  parameter rom_check_pkg::rom_image_t Image = '0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rom_check_pkg::rom_req_t req_i,
  output rom_check_pkg::rom_rsp_t rsp_o
);
  import rom_check_pkg::*;

  logic [DataW-1:0] mem [RomDepth];
  logic [DataW-1:0] rdata_q;
  logic             rvalid_q;

  // Array is a plain copy of the image, there is no write port
  for (genvar i = 0; i < RomDepth; i++) begin : g_mem
    assign mem[i] = Image[i];
  end

  // Output register only loads on a request, so it holds when reads stop
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= mem[req_i.addr];
    end
  end

  // rvalid trails the request by exactly one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* hw/rom_check/rom_check_digest.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Absorbs one word per DigestRounds+1 cycles at best
// State restarts from DigestInit only on reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rom_check_digest (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              in_vld_i,
  input  logic [rom_check_pkg::DataW-1:0]   in_data_i,
  output logic                              in_rdy_o,
  output logic                              idle_o,
  output logic [rom_check_pkg::DigestW-1:0] digest_o
);
  import rom_check_pkg::*;

  logic [DigestW-1:0]   state_q;
  logic [DataW-1:0]     word_q;
  logic [RoundCntW-1:0] rounds_q;
  logic                 busy;
  logic                 accept;

  assign busy   = rounds_q != '0;
  assign accept = in_vld_i & ~busy;

  // Word register is payload and only loads on accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_q <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= DigestInit;
      rounds_q <= '0;
    end else if (accept) begin
      rounds_q <= RoundCntW'(DigestRounds);
    end else if (busy) begin
      // Sub-round index counts up from 0 as rounds_q counts down
      state_q  <= digest_round(state_q, word_q, DigestRounds - int'(rounds_q));
      rounds_q <= rounds_q - RoundCntW'(1);
    end
  end

  assign in_rdy_o = ~busy;
  assign idle_o   = ~busy;
  assign digest_o = state_q;

  // Each accepted word blocks the input for the full round count
  RdyLowInRounds_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_vld_i && in_rdy_o |=> !in_rdy_o [*DigestRounds] ##1 in_rdy_o);

endmodule

`default_nettype wire

/* hw/rom_check/rom_check_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Status is written once per reset and then frozen
// Top words are placed by the low address bits, so RomTopCount must be a power of two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rom_check_fsm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              data_vld_i,
  input  logic                              data_last_nontop_i,
  input  logic                              counter_done_i,
  input  logic                              digest_idle_i,
  input  logic [rom_check_pkg::AddrW-1:0]   data_addr_i,
  input  logic [rom_check_pkg::DataW-1:0]   rom_data_i,
  input  logic [rom_check_pkg::DigestW-1:0] digest_i,
  input  logic                              digest_rdy_i,
  output logic                              data_rdy_o,
  output logic                              digest_vld_o,
  output rom_check_pkg::check_status_t      status_o
);
  import rom_check_pkg::*;

  typedef enum logic [1:0] {
    StHash    = 2'd0,
    StTop     = 2'd1,
    StWait    = 2'd2,
    StCompare = 2'd3
  } state_e;

  state_e state_q;
  state_e state_d;

  logic [RomTopCount-1:0][DataW-1:0] exp_q;
  check_status_t                     status_q;
  logic                              top_idx;

  // Low address bit selects which half of the expected digest a top word fills
  assign top_idx = data_addr_i[0];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StHash: begin
        // Last hashed word has to be taken by the engine before moving on
        if (data_vld_i && digest_rdy_i && data_last_nontop_i) begin
          state_d = StTop;
        end
      end
      StTop: begin
        if (counter_done_i) begin
          state_d = StWait;
        end
      end
      StWait: begin
        // Engine may still be mixing the last word
        if (digest_idle_i) begin
          state_d = StCompare;
        end
      end
      default: begin
        state_d = StCompare;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StHash;
    end else begin
      state_q <= state_d;
    end
  end

  // Every top word goes into the expected digest as soon as it is valid
  always_ff @(posedge clk_i) begin
    if (state_q == StTop && data_vld_i) begin
      exp_q[top_idx] <= rom_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else if (state_q == StCompare && !status_q.done) begin
      status_q <= '{done: 1'b1, good: exp_q == digest_i};
    end
  end

  // Digest sets the pace while hashing and top words are always taken
  assign data_rdy_o   = (state_q == StHash) ? digest_rdy_i : (state_q == StTop);
  assign digest_vld_o = (state_q == StHash) & data_vld_i;
  assign status_o     = status_q;

  // A status only exists once the counter has finished and the engine has drained
  StatusAfterDrain_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    status_q.done |-> counter_done_i && digest_idle_i);

endmodule

`default_nettype wire

/* hw/rom_check/rom_check_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Once the bus owns the ROM it keeps it until reset
// Bus requests before that are dropped without a response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rom_check_mux (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    sel_bus_i,
  input  rom_check_pkg::rom_req_t chk_req_i,
  input  rom_check_pkg::rom_req_t bus_req_i,
  input  rom_check_pkg::rom_rsp_t rom_rsp_i,
  output rom_check_pkg::rom_req_t rom_req_o,
  output rom_check_pkg::rom_rsp_t bus_rsp_o
);
  import rom_check_pkg::*;

  logic sel_q;
  logic sel;
  logic bus_rd_q;

  // The live select lets a bus read through in the very cycle done rises
  assign sel = sel_q | sel_bus_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q    <= 1'b0;
      bus_rd_q <= 1'b0;
    end else begin
      sel_q    <= sel;
      // Marks the ROM response in flight as belonging to the bus
      bus_rd_q <= sel & bus_req_i.req;
    end
  end

  assign rom_req_o = sel ? bus_req_i : chk_req_i;
  assign bus_rsp_o = '{rvalid: rom_rsp_i.rvalid & bus_rd_q, rdata: rom_rsp_i.rdata};

  // A bus read that reaches the ROM gets its rvalid back on the next cycle
  BusRspNext_A: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sel && bus_req_i.req |=> bus_rsp_o.rvalid);

endmodule

`default_nettype wire

/* hw/rom_check_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// The check runs once after each reset and status_o.done marks its end
// Bus reads only return data after that point
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rom_check_top #(
  parameter rom_check_pkg::rom_image_t Image = rom_check_pkg::build_image()
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  rom_check_pkg::rom_req_t      bus_req_i,
  output rom_check_pkg::rom_rsp_t      bus_rsp_o,
  output rom_check_pkg::check_status_t status_o
);
  import rom_check_pkg::*;

  rom_req_t           chk_req;
  rom_req_t           rom_req;
  rom_rsp_t           rom_rsp;
  logic               data_vld;
  logic               data_rdy;
  logic               data_last_nontop;
  logic               counter_done;
  logic [AddrW-1:0]   data_addr;
  logic               digest_vld;
  logic               digest_rdy;
  logic               digest_idle;
  logic [DigestW-1:0] digest;

  rom_check_counter i_counter (
    .clk_i,
    .rst_ni,
    .data_rdy_i         (data_rdy),
    .rom_req_o          (chk_req),
    .data_vld_o         (data_vld),
    .data_last_nontop_o (data_last_nontop),
    .done_o             (counter_done),
    .data_addr_o        (data_addr)
  );

  rom_check_rom #(
    .Image (Image)
  ) i_rom (
    .clk_i,
    .rst_ni,
    .req_i (rom_req),
    .rsp_o (rom_rsp)
  );

  // Engine reads the ROM output register directly
  rom_check_digest i_digest (
    .clk_i,
    .rst_ni,
    .in_vld_i  (digest_vld),
    .in_data_i (rom_rsp.rdata),
    .in_rdy_o  (digest_rdy),
    .idle_o    (digest_idle),
    .digest_o  (digest)
  );

  rom_check_fsm i_fsm (
    .clk_i,
    .rst_ni,
    .data_vld_i         (data_vld),
    .data_last_nontop_i (data_last_nontop),
    .counter_done_i     (counter_done),
    .digest_idle_i      (digest_idle),
    .data_addr_i        (data_addr),
    .rom_data_i         (rom_rsp.rdata),
    .digest_i           (digest),
    .digest_rdy_i       (digest_rdy),
    .data_rdy_o         (data_rdy),
    .digest_vld_o       (digest_vld),
    .status_o           (status_o)
  );

  // Status done hands the ROM over to the bus for good
  rom_check_mux i_mux (
    .clk_i,
    .rst_ni,
    .sel_bus_i (status_o.done),
    .chk_req_i (chk_req),
    .bus_req_i (bus_req_i),
    .rom_rsp_i (rom_rsp),
    .rom_req_o (rom_req),
    .bus_rsp_o (bus_rsp_o)
  );

endmodule

`default_nettype wire

/* verification/rom_check_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Runs a good and a corrupted DUT side by side from one clock and reset
// Bus traffic goes to the good DUT only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rom_check_tb;
  import rom_check_pkg::*;

  // Worst case check latency where every word costs DigestRounds+1 cycles plus some margin
  localparam int CheckCycles   = RomDepth * (DigestRounds + 1) + 20;
  // Covers seven resets with their checks, the 50 hold cycles and the bus traffic with room
  localparam int TimeoutCycles = 1500;
  localparam int BusReads      = 20;

  localparam rom_image_t GoodImage = build_image();
  // Nontop word 7 gets its lowest bit flipped
  localparam rom_image_t BadImage  = GoodImage ^ (rom_image_t'(1) << (7 * DataW));

  logic          clk_i;
  logic          rst_ni;
  rom_req_t      bus_req;
  rom_rsp_t      bus_rsp;
  check_status_t status;
  rom_req_t      bad_bus_req;
  rom_rsp_t      bad_bus_rsp;
  check_status_t bad_status;

  rom_image_t  model_img;
  logic        model_good;
  logic        model_bad_good;
  logic [31:0] lcg_state;
  int          cycle_cnt;
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;
  logic        reset_glitch;

  rom_check_top #(.Image(GoodImage)) i_dut (
    .clk_i,
    .rst_ni,
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .status_o  (status)
  );

  rom_check_top #(.Image(BadImage)) i_dut_bad (
    .clk_i,
    .rst_ni,
    .bus_req_i (bad_bus_req),
    .bus_rsp_o (bad_bus_rsp),
    .status_o  (bad_status)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Watchdog over the whole run
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Run did not finish within %0d cycles", TimeoutCycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // The top bits of this LCG have the longest period
  function automatic logic [AddrW-1:0] lcg_addr();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31 -: AddrW];
  endfunction

  // True when the stored top words match the digest of the nontop words
  function automatic logic image_is_good(input rom_image_t img);
    logic [DigestW-1:0] d;
    d = DigestInit;
    for (int a = 0; a < RomNonTopCount; a++) begin
      d = digest_step(d, img[a]);
    end
    return d == {img[RomDepth-1], img[RomDepth-2]};
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [63:0] exp, input logic [63:0] act);
    $display("CHECK FAILED %s %s: expected %0h, actual %0h", name, what, exp, act);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      $display("[ok]  %s", name);
      pass_cnt++;
    end else begin
      $display("[bad] %s with %0d errors", name, test_errs);
      fail_cnt++;
    end
    test_errs = 0;
  endtask

  // Holds reset for 3 cycles and notes any nonzero status or rvalid meanwhile
  task automatic apply_reset();
    @(posedge clk_i);
    #1;
    rst_ni  = 1'b0;
    bus_req = '0;
    reset_glitch = 1'b0;
    repeat (3) begin
      @(posedge clk_i);
      #1;
      if (status !== '0 || bad_status !== '0 ||
          bus_rsp.rvalid !== 1'b0 || bad_bus_rsp.rvalid !== 1'b0) begin
        reset_glitch = 1'b1;
      end
    end
    rst_ni = 1'b1;
  endtask

  task automatic wait_for_done(input string name, input logic use_bad, output logic seen);
    int n;
    check_status_t st;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < CheckCycles) begin
      @(posedge clk_i);
      #1;
      st   = use_bad ? bad_status : status;
      seen = st.done;
      n++;
    end
    if (!seen) begin
      $display("%s: status done did not rise within %0d cycles", name, CheckCycles);
      test_errs++;
    end
  endtask

  // Back-to-back reads where the first two hit the top words
  task automatic run_bus_reads(input string name);
    logic [AddrW-1:0] addr;
    logic             pending;
    pending = 1'b0;
    addr    = '0;
    for (int i = 0; i <= BusReads; i++) begin
      @(posedge clk_i);
      #1;
      if (bus_rsp.rvalid !== pending) begin
        report_mismatch(name, "rvalid", pending, bus_rsp.rvalid);
      end else if (pending && bus_rsp.rdata !== model_img[addr]) begin
        report_mismatch(name, "rdata", model_img[addr], bus_rsp.rdata);
      end
      if (i < BusReads) begin
        addr    = (i < RomTopCount) ? AddrW'(RomNonTopCount + i) : lcg_addr();
        bus_req = '{req: 1'b1, addr: addr};
        pending = 1'b1;
      end else begin
        bus_req = '0;
        pending = 1'b0;
      end
    end
    @(posedge clk_i);
    #1;
    if (bus_rsp.rvalid !== 1'b0) begin
      report_mismatch(name, "rvalid after last read", 0, bus_rsp.rvalid);
    end
  endtask

  task automatic reset_clears_outputs();
    apply_reset();
    if (reset_glitch) begin
      $display("reset_state: status or rvalid was nonzero during reset");
      test_errs++;
    end
    @(posedge clk_i);
    #1;
    if (status !== '0) begin
      report_mismatch("reset_state", "status", 0, status);
    end
    if (bus_rsp.rvalid !== 1'b0) begin
      report_mismatch("reset_state", "rvalid", 0, bus_rsp.rvalid);
    end
    finish_test("reset_state");
  endtask

  task automatic good_image_passes();
    logic seen;
    apply_reset();
    wait_for_done("good_image", 1'b0, seen);
    if (seen && status.good !== model_good) begin
      report_mismatch("good_image", "good", model_good, status.good);
    end
    // Status must hold once set
    repeat (50) begin
      @(posedge clk_i);
      #1;
      if (seen && status !== check_status_t'{done: 1'b1, good: model_good}) begin
        report_mismatch("good_image", "held status", {1'b1, model_good}, status);
      end
    end
    finish_test("good_image");
  endtask

  task automatic bad_image_fails();
    logic seen;
    apply_reset();
    wait_for_done("bad_image", 1'b1, seen);
    if (seen && bad_status.good !== model_bad_good) begin
      report_mismatch("bad_image", "good", model_bad_good, bad_status.good);
    end
    finish_test("bad_image");
  endtask

  task automatic bus_blocked_during_check();
    int   n;
    logic issued;
    apply_reset();
    n      = 0;
    issued = 1'b0;
    while (n < CheckCycles) begin
      @(posedge clk_i);
      #1;
      if (issued && bus_rsp.rvalid !== 1'b0) begin
        report_mismatch("bus_blocked", "rvalid", 0, bus_rsp.rvalid);
      end
      if (status.done) begin
        n = CheckCycles;
      end else begin
        bus_req = '{req: 1'b1, addr: lcg_addr()};
        issued  = 1'b1;
        n++;
      end
    end
    bus_req = '0;
    if (!status.done) begin
      $display("bus_blocked: status done did not rise within %0d cycles", CheckCycles);
      test_errs++;
    end
    // The last request went out before done, so nothing comes back
    @(posedge clk_i);
    #1;
    if (bus_rsp.rvalid !== 1'b0) begin
      report_mismatch("bus_blocked", "late rvalid", 0, bus_rsp.rvalid);
    end
    finish_test("bus_blocked");
  endtask

  task automatic bus_reads_after_check();
    logic seen;
    apply_reset();
    wait_for_done("bus_reads", 1'b0, seen);
    run_bus_reads("bus_reads");
    finish_test("bus_reads");
  endtask

  task automatic rerun_after_reset();
    logic seen;
    apply_reset();
    wait_for_done("repeat_reset", 1'b0, seen);
    // Second reset hits a finished check with a bus read in flight
    bus_req = '{req: 1'b1, addr: lcg_addr()};
    apply_reset();
    if (reset_glitch) begin
      $display("repeat_reset: status or rvalid was nonzero during the second reset");
      test_errs++;
    end
    wait_for_done("repeat_reset", 1'b0, seen);
    if (seen && status.good !== model_good) begin
      report_mismatch("repeat_reset", "good", model_good, status.good);
    end
    run_bus_reads("repeat_reset");
    finish_test("repeat_reset");
  endtask

  initial begin
    rst_ni      = 1'b0;
    bus_req     = '0;
    bad_bus_req = '0;
    lcg_state   = 32'hbaae;
    cycle_cnt   = 0;
    test_errs   = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    reset_glitch = 1'b0;

    // Reference image and the result the check should reach on each DUT
    model_img      = build_image();
    model_good     = image_is_good(model_img);
    model_bad_good = image_is_good(model_img ^ (rom_image_t'(1) << (7 * DataW)));

    reset_clears_outputs();
    good_image_passes();
    bad_image_fails();
    bus_blocked_during_check();
    bus_reads_after_check();
    rerun_after_reset();

    $display("Summary: %0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
common/rom_check_pkg.sv
hw/rom_check/rom_check_counter.sv
hw/rom_check/rom_check_rom.sv
hw/rom_check/rom_check_digest.sv
hw/rom_check/rom_check_fsm.sv
hw/rom_check/rom_check_mux.sv
hw/rom_check_top.sv
verification/rom_check_tb.sv

/* Bender.yml */
package:
  name: rom_check

sources:
  - common/rom_check_pkg.sv
  - hw/rom_check/rom_check_counter.sv
  - hw/rom_check/rom_check_rom.sv
  - hw/rom_check/rom_check_digest.sv
  - hw/rom_check/rom_check_fsm.sv
  - hw/rom_check/rom_check_mux.sv
  - hw/rom_check_top.sv
  - target: test
    files:
      - verification/rom_check_tb.sv
